// File: design/rom_pkg.sv
`default_nettype none

package rom_pkg;

	// ####################
	// Widths
	localparam int LOAD_ADDR_W    = 25;   // Host download address
	localparam int PROG_ADDR_W    = 19;   // Main CPU ROM address
	localparam int PROG_BANK32_AW = 15;   // 32K word program banks
	localparam int PROG_BANK16_AW = 14;   // 10A/10B only
	localparam int SND_BANK32_AW  = 15;   // 16S
	localparam int SND_BANK16_AW  = 14;   // 16R
	localparam int CHAR_AW        = 14;   // 6P

	// Download file indices
	localparam logic [7:0] ROM_IDX  = 8'd0;
	localparam logic [7:0] GAME_IDX = 8'd1;
	localparam logic [7:0] DIP_IDX  = 8'd254;

	// ####################
	// Load targets, one bit each in bank_sel
	localparam int NUM_BANKS = 9;
	localparam int BANK_9AB  = 0;
	localparam int BANK_10AB = 1;
	localparam int BANK_7AB  = 2;
	localparam int BANK_6AB  = 3;
	localparam int BANK_5AB  = 4;
	localparam int BANK_3AB  = 5;   // Last program bank
	localparam int BANK_16S  = 6;   // First byte bank
	localparam int BANK_16R  = 7;
	localparam int BANK_6P   = 8;

	// Region codes on the download address
	localparam logic [8:0]  REG_9AB  = 9'h0C;    // 0C0000..0CFFFF
	localparam logic [9:0]  REG_10AB = 10'h1E;   // 0F0000..0F7FFF
	localparam logic [8:0]  REG_7AB  = 9'h10;
	localparam logic [8:0]  REG_6AB  = 9'h11;
	localparam logic [8:0]  REG_5AB  = 9'h12;
	localparam logic [8:0]  REG_3AB  = 9'h13;
	localparam logic [9:0]  REG_16S  = 10'h28;   // Bits 24:15
	localparam logic [10:0] REG_16R  = 11'h52;   // Bits 24:14
	localparam logic [10:0] REG_6P   = 11'h53;

	// Program read selectors, top bits of mp_addr
	localparam logic [3:0] PSEL_9AB  = 4'b0000;
	localparam logic [4:0] PSEL_10AB = 5'b00110;   // Half size bank, five bits
	localparam logic [3:0] PSEL_7AB  = 4'b0100;
	localparam logic [3:0] PSEL_6AB  = 4'b0101;
	localparam logic [3:0] PSEL_5AB  = 4'b0110;
	localparam logic [3:0] PSEL_3AB  = 4'b0111;

	// Download address, 64K and 32K region layouts
	typedef union packed {
		struct packed {
			logic [8:0]  region;
			logic [14:0] word;
			logic        lane;   // 1 = second byte of a word
		} blk32;
		struct packed {
			logic [9:0]  region;
			logic [13:0] word;
			logic        lane;
		} blk16;
	} load_addr_u;

endpackage

`default_nettype wire

// File: design/rom_wr_if.sv
`timescale 1ns/1ns
`default_nettype none

// One ROM write, decoder to banks
interface rom_wr_if import rom_pkg::*; ();

	logic [NUM_BANKS-1:0]      bank_sel;   // One-hot target
	logic [PROG_BANK32_AW-1:0] wr_addr;    // Word or byte offset
	logic [15:0]               wr_data;    // Byte banks take [7:0]
	logic                      wr_en;      // Single cycle

	modport loader (
		output bank_sel,
		output wr_addr,
		output wr_data,
		output wr_en
	);

	modport bank (
		input bank_sel,
		input wr_addr,
		input wr_data,
		input wr_en
	);

endinterface

`default_nettype wire

// File: design/rom_bank.sv
`timescale 1ns/1ns
`default_nettype none

module rom_bank #(
	parameter int ADDR_W = 14,
	parameter int DATA_W = 8
) (
	input wire               clk_sys,
	input wire               wr_en,
	input wire  [ADDR_W-1:0] wr_addr,
	input wire  [DATA_W-1:0] wr_data,
	input wire  [ADDR_W-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data
);

	// Maps onto block RAM, one write and one read port
	logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;   // Load port
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: design/load_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module load_decoder import rom_pkg::*; (
	input wire                   clk_sys,
	input wire                   rst,
	input wire                   ioctl_download,
	input wire                   ioctl_wr,
	input wire [7:0]             ioctl_index,
	input wire [LOAD_ADDR_W-1:0] ioctl_addr,
	input wire [7:0]             ioctl_dout,
	rom_wr_if.loader             wr
);

	load_addr_u                la;          // Address, both views
	logic                      rom_stb;     // Accepted ROM byte
	logic [NUM_BANKS-1:0]      hit;         // Region match per bank
	logic                      prog_hit;
	logic                      byte_hit;
	logic [PROG_BANK32_AW-1:0] addr_d;
	logic [7:0]                last_byte;   // Previous accepted byte

	assign la = ioctl_addr;
	assign rom_stb = ioctl_wr && ioctl_download && (ioctl_index == ROM_IDX);

	// ####################
	// Region decode
	always_comb begin
		hit = '0;
		hit[BANK_9AB]  = (la.blk32.region == REG_9AB);
		hit[BANK_10AB] = (la.blk16.region == REG_10AB);   // 32K region
		hit[BANK_7AB]  = (la.blk32.region == REG_7AB);
		hit[BANK_6AB]  = (la.blk32.region == REG_6AB);
		hit[BANK_5AB]  = (la.blk32.region == REG_5AB);
		hit[BANK_3AB]  = (la.blk32.region == REG_3AB);
		hit[BANK_16S]  = (la.blk16.region == REG_16S);
		// 16K regions, one bit finer than blk16
		hit[BANK_16R]  = (ioctl_addr[LOAD_ADDR_W-1:14] == REG_16R);
		hit[BANK_6P]   = (ioctl_addr[LOAD_ADDR_W-1:14] == REG_6P);
	end

	assign prog_hit = |hit[BANK_3AB:BANK_9AB];
	assign byte_hit = |hit[BANK_6P:BANK_16S];

	// Word offset for program banks, byte offset otherwise
	always_comb begin
		if (hit[BANK_10AB]) begin
			addr_d = {1'b0, la.blk16.word};
		end else if (prog_hit) begin
			addr_d = la.blk32.word;
		end else begin
			addr_d = ioctl_addr[PROG_BANK32_AW-1:0];
		end
	end

	// ####################
	// Write strobe and accumulator
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr.wr_en  <= 1'b0;
			last_byte <= 8'h00;
		end else begin
			wr.wr_en <= 1'b0;   // Pulse only
			if (rom_stb) begin
				last_byte <= ioctl_dout;
				// Program words go out on the odd byte
				if (byte_hit || (prog_hit && la.blk32.lane)) begin
					wr.wr_en <= 1'b1;
				end
			end
		end
	end

	// Payload, taken with every accepted byte
	always_ff @(posedge clk_sys) begin
		if (rom_stb) begin
			wr.bank_sel <= hit;
			wr.wr_addr  <= addr_d;
			wr.wr_data  <= {last_byte, ioctl_dout};   // First byte high
		end
	end

endmodule

`default_nettype wire

// File: design/program_rom.sv
`timescale 1ns/1ns
`default_nettype none

module program_rom import rom_pkg::*; (
	input wire                   clk_sys,
	rom_wr_if.bank               wr,
	input wire [PROG_ADDR_W-1:0] mp_addr,
	output logic [15:0]          mp_data
);

	logic [15:0] bank_q [BANK_9AB:BANK_3AB];   // Read data per bank
	logic [2:0]  psel_d;                       // Bank number for mp_addr
	logic        pvld_d;                       // mp_addr hits a bank
	logic [2:0]  psel_q;
	logic        pvld_q;

	// ####################
	// Banks 9A/9B .. 3A/3B
	for (genvar i = BANK_9AB; i <= BANK_3AB; i++) begin : g_bank
		// 10A/10B is half size
		localparam int AW = (i == BANK_10AB) ? PROG_BANK16_AW : PROG_BANK32_AW;

		rom_bank #(
			.ADDR_W(AW),
			.DATA_W(16)
		) u_bank (
			.clk_sys(clk_sys),
			.wr_en  (wr.wr_en && wr.bank_sel[i]),
			.wr_addr(wr.wr_addr[AW-1:0]),
			.wr_data(wr.wr_data),
			.rd_addr(mp_addr[AW-1:0]),
			.rd_data(bank_q[i])
		);
	end

	// ####################
	// Read select from the top address bits
	always_comb begin
		psel_d = 3'(BANK_9AB);
		pvld_d = 1'b1;
		if (mp_addr[PROG_ADDR_W-1 -: 4] == PSEL_9AB) begin
			psel_d = 3'(BANK_9AB);
		end else if (mp_addr[PROG_ADDR_W-1 -: 5] == PSEL_10AB) begin
			psel_d = 3'(BANK_10AB);
		end else if (mp_addr[PROG_ADDR_W-1 -: 4] == PSEL_7AB) begin
			psel_d = 3'(BANK_7AB);
		end else if (mp_addr[PROG_ADDR_W-1 -: 4] == PSEL_6AB) begin
			psel_d = 3'(BANK_6AB);
		end else if (mp_addr[PROG_ADDR_W-1 -: 4] == PSEL_5AB) begin
			psel_d = 3'(BANK_5AB);
		end else if (mp_addr[PROG_ADDR_W-1 -: 4] == PSEL_3AB) begin
			psel_d = 3'(BANK_3AB);
		end else begin
			pvld_d = 1'b0;   // Unmapped, reads zero
		end
	end

	// Select follows the RAM read by one cycle
	always_ff @(posedge clk_sys) begin
		psel_q <= psel_d;
		pvld_q <= pvld_d;
	end

	assign mp_data = pvld_q ? bank_q[psel_q] : 16'h0000;

endmodule

`default_nettype wire

// File: design/sound_char_rom.sv
`timescale 1ns/1ns
`default_nettype none

module sound_char_rom import rom_pkg::*; (
	input wire                   clk_sys,
	rom_wr_if.bank               wr,
	input wire [SND_BANK32_AW:0] ap_addr,   // Bit 15 picks 16S
	output logic [7:0]           ap_data,
	input wire [CHAR_AW-1:0]     cp_addr,
	output logic [7:0]           cp_data
);

	logic [7:0] q_16s;
	logic [7:0] q_16r;
	logic       ap_hi_q;   // ap_addr[15] at read time

	// ####################
	// Audio CPU ROMs
	rom_bank #(
		.ADDR_W(SND_BANK32_AW),
		.DATA_W(8)
	) u_16s (
		.clk_sys(clk_sys),
		.wr_en  (wr.wr_en && wr.bank_sel[BANK_16S]),
		.wr_addr(wr.wr_addr[SND_BANK32_AW-1:0]),
		.wr_data(wr.wr_data[7:0]),
		.rd_addr(ap_addr[SND_BANK32_AW-1:0]),
		.rd_data(q_16s)
	);

	rom_bank #(
		.ADDR_W(SND_BANK16_AW),
		.DATA_W(8)
	) u_16r (
		.clk_sys(clk_sys),
		.wr_en  (wr.wr_en && wr.bank_sel[BANK_16R]),
		.wr_addr(wr.wr_addr[SND_BANK16_AW-1:0]),
		.wr_data(wr.wr_data[7:0]),
		.rd_addr(ap_addr[SND_BANK16_AW-1:0]),   // Mirrors in the lower 32K
		.rd_data(q_16r)
	);

	always_ff @(posedge clk_sys) begin
		ap_hi_q <= ap_addr[SND_BANK32_AW];
	end

	assign ap_data = ap_hi_q ? q_16s : q_16r;

	// Character ROM 6P, read straight through
	rom_bank #(
		.ADDR_W(CHAR_AW),
		.DATA_W(8)
	) u_6p (
		.clk_sys(clk_sys),
		.wr_en  (wr.wr_en && wr.bank_sel[BANK_6P]),
		.wr_addr(wr.wr_addr[CHAR_AW-1:0]),
		.wr_data(wr.wr_data[7:0]),
		.rd_addr(cp_addr),
		.rd_data(cp_data)
	);

endmodule

`default_nettype wire

// File: design/config_regs.sv
`timescale 1ns/1ns
`default_nettype none

module config_regs import rom_pkg::*; #(
	parameter logic [7:0] DEFAULT_GAME_TYPE = 8'd104
) (
	input wire                   clk_sys,
	input wire                   rst,
	input wire                   ioctl_wr,
	input wire [7:0]             ioctl_index,
	input wire [LOAD_ADDR_W-1:0] ioctl_addr,
	input wire [7:0]             ioctl_dout,
	output logic [63:0]          dip_sw,      // Byte n at [8n+7:8n]
	output logic [7:0]           game_type
);

	logic dip_stb;
	logic game_stb;

	// Only the first eight bytes of the DIP file count
	assign dip_stb  = ioctl_wr && (ioctl_index == DIP_IDX) && (ioctl_addr[LOAD_ADDR_W-1:3] == '0);
	assign game_stb = ioctl_wr && (ioctl_index == GAME_IDX);

	// ####################
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dip_sw    <= '0;
			game_type <= DEFAULT_GAME_TYPE;   // Gauntlet
		end else begin
			if (dip_stb) begin
				dip_sw[ioctl_addr[2:0]*8 +: 8] <= ioctl_dout;
			end
			if (game_stb) begin
				game_type <= ioctl_dout;   // Slapstic type
			end
		end
	end

endmodule

`default_nettype wire

// File: design/rom_loader_top.sv
`timescale 1ns/1ns
`default_nettype none

module rom_loader_top import rom_pkg::*; #(
	parameter logic [7:0] DEFAULT_GAME_TYPE = 8'd104
) (
	input wire                    clk_sys,
	input wire                    rst,

	// Host download stream
	input wire                    ioctl_download,
	input wire                    ioctl_wr,
	input wire [7:0]              ioctl_index,
	input wire [LOAD_ADDR_W-1:0]  ioctl_addr,
	input wire [7:0]              ioctl_dout,

	// Main CPU program read
	input wire [PROG_ADDR_W-1:0]  mp_addr,
	output logic [15:0]           mp_data,

	// Audio CPU read
	input wire [SND_BANK32_AW:0]  ap_addr,
	output logic [7:0]            ap_data,

	// Character read
	input wire [CHAR_AW-1:0]      cp_addr,
	output logic [7:0]            cp_data,

	output logic [63:0]           dip_sw,
	output logic [7:0]            game_type
);

	rom_wr_if wr_bus ();   // Decoder to all ROMs

	// ####################
	load_decoder u_decoder (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.ioctl_download(ioctl_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_index   (ioctl_index),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.wr            (wr_bus.loader)
	);

	program_rom u_program (
		.clk_sys(clk_sys),
		.wr     (wr_bus.bank),
		.mp_addr(mp_addr),
		.mp_data(mp_data)
	);

	sound_char_rom u_sound_char (
		.clk_sys(clk_sys),
		.wr     (wr_bus.bank),
		.ap_addr(ap_addr),
		.ap_data(ap_data),
		.cp_addr(cp_addr),
		.cp_data(cp_data)
	);

	// DIP and game type ride the same stream
	config_regs #(
		.DEFAULT_GAME_TYPE(DEFAULT_GAME_TYPE)
	) u_config (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ioctl_wr   (ioctl_wr),
		.ioctl_index(ioctl_index),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.dip_sw     (dip_sw),
		.game_type  (game_type)
	);

endmodule

`default_nettype wire

// File: tests/rom_loader_checker.sv
`timescale 1ns/1ns
`default_nettype none

// Write-side rules of the load decoder
module rom_loader_checker import rom_pkg::*; (
	input wire                   clk_sys,
	input wire                   rst,
	input wire                   ioctl_download,
	input wire                   ioctl_wr,
	input wire [7:0]             ioctl_index,
	input wire [LOAD_ADDR_W-1:0] ioctl_addr,
	input wire                   wr_en,
	input wire [NUM_BANKS-1:0]   bank_sel
);

	load_addr_u la;                // Download address, both views
	logic       accepted;          // ROM byte taken this cycle
	int         err_count = 0;     // Failed assertions so far

	assign la = ioctl_addr;
	assign accepted = ioctl_wr && ioctl_download && (ioctl_index == ROM_IDX);

	// ####################
	a_onehot: assert property (@(posedge clk_sys) disable iff (rst)
		wr_en |-> $onehot(bank_sel))
	else begin
		err_count++;
		$error("bank_sel is not one-hot during a ROM write");
	end

	a_strobe: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(wr_en) |-> $past(accepted))
	else begin
		err_count++;
		$error("ROM write without an accepted strobe one cycle before");
	end

	a_download: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(wr_en) |-> $past(ioctl_download))
	else begin
		err_count++;
		$error("ROM write while the download level was low");
	end

	// Program words only on the second byte
	a_lane: assert property (@(posedge clk_sys) disable iff (rst)
		($rose(wr_en) && (|bank_sel[BANK_3AB:BANK_9AB])) |-> $past(la.blk32.lane))
	else begin
		err_count++;
		$error("Program word written on the first byte of a pair");
	end

endmodule

bind load_decoder rom_loader_checker chk0 (
	.clk_sys       (clk_sys),
	.rst           (rst),
	.ioctl_download(ioctl_download),
	.ioctl_wr      (ioctl_wr),
	.ioctl_index   (ioctl_index),
	.ioctl_addr    (ioctl_addr),
	.wr_en         (wr.wr_en),
	.bank_sel      (wr.bank_sel)
);

`default_nettype wire

// File: tests/rom_loader_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rom_loader_tb import rom_pkg::*; ();

	typedef struct packed {
		logic [3:0]  bank;      // Target bank number
		logic [14:0] offset;    // Word offset or byte bank offset
		logic [7:0]  b0;        // First byte
		logic [7:0]  b1;
		logic [18:0] rd_addr;   // mp_addr, ap_addr or cp_addr
		logic [15:0] exp_val;
	} entry_t;

	localparam logic [3:0] NO_LOAD = 4'hF;   // Read only entry
	localparam int N_ENTRIES = 12;
	localparam int WATCHDOG_CYCLES = N_ENTRIES * 8 + 200;

	localparam entry_t TABLE [N_ENTRIES] = '{
		'{4'(BANK_9AB), 15'h0000, 8'h12, 8'h34, 19'({PSEL_9AB, 15'h0000}), 16'h1234},
		'{4'(BANK_9AB), 15'h7FFF, 8'hA5, 8'h5A, 19'({PSEL_9AB, 15'h7FFF}), 16'hA55A},
		'{4'(BANK_10AB), 15'h0010, 8'hC3, 8'h3C, 19'({PSEL_10AB, 14'h0010}), 16'hC33C},
		'{4'(BANK_7AB), 15'h0123, 8'hDE, 8'hAD, 19'({PSEL_7AB, 15'h0123}), 16'hDEAD},
		'{4'(BANK_6AB), 15'h0456, 8'hBE, 8'hEF, 19'({PSEL_6AB, 15'h0456}), 16'hBEEF},
		'{4'(BANK_5AB), 15'h1000, 8'hCA, 8'hFE, 19'({PSEL_5AB, 15'h1000}), 16'hCAFE},
		'{4'(BANK_3AB), 15'h7FFE, 8'h0F, 8'hF0, 19'({PSEL_3AB, 15'h7FFE}), 16'h0FF0},
		'{4'(BANK_16S), 15'h0042, 8'h77, 8'h88, 19'h08042, 16'h0077},
		'{4'(BANK_16S), 15'h7FF0, 8'h19, 8'h2B, 19'h0FFF1, 16'h002B},
		'{4'(BANK_16R), 15'h0042, 8'h91, 8'h92, 19'h00043, 16'h0092},
		'{4'(BANK_6P), 15'h3FFE, 8'h6E, 8'h6F, 19'h03FFE, 16'h006E},
		'{NO_LOAD, 15'h0000, 8'h00, 8'h00, 19'h40000, 16'h0000}   // No selector
	};

	logic                   clk_sys;
	logic                   rst;
	logic                   ioctl_download;
	logic                   ioctl_wr;
	logic [7:0]             ioctl_index;
	logic [LOAD_ADDR_W-1:0] ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic [PROG_ADDR_W-1:0] mp_addr;
	logic [15:0]            mp_data;
	logic [15:0]            ap_addr;
	logic [7:0]             ap_data;
	logic [CHAR_AW-1:0]     cp_addr;
	logic [7:0]             cp_data;
	logic [63:0]            dip_sw;
	logic [7:0]             game_type;
	integer                 seed = 32'hb17c684e;

	rom_loader_top #(
		.DEFAULT_GAME_TYPE(8'd104)
	) dut0 (
		.clk_sys(clk_sys), .rst(rst),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.mp_addr(mp_addr), .mp_data(mp_data), .ap_addr(ap_addr), .ap_data(ap_data),
		.cp_addr(cp_addr), .cp_data(cp_data), .dip_sw(dip_sw), .game_type(game_type)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ####################
	// Download address from region code, offset and byte lane
	function automatic logic [LOAD_ADDR_W-1:0] load_addr(input logic [3:0] bank,
			input logic [14:0] offset, input logic lane);
		logic [14:0] byte_off;
		byte_off = offset + 15'(lane);   // Byte banks take the pair at offset and offset+1
		case (int'(bank))
			BANK_9AB: load_addr = {REG_9AB, offset, lane};
			BANK_10AB: load_addr = {REG_10AB, offset[13:0], lane};
			BANK_7AB: load_addr = {REG_7AB, offset, lane};
			BANK_6AB: load_addr = {REG_6AB, offset, lane};
			BANK_5AB: load_addr = {REG_5AB, offset, lane};
			BANK_3AB: load_addr = {REG_3AB, offset, lane};
			BANK_16S: load_addr = {REG_16S, byte_off};
			BANK_16R: load_addr = {REG_16R, byte_off[13:0]};
			default: load_addr = {REG_6P, byte_off[13:0]};
		endcase
	endfunction

	function automatic string port_name(input logic [3:0] bank);
		if (int'(bank) == BANK_16S || int'(bank) == BANK_16R) begin
			port_name = "ap_data";
		end else if (int'(bank) == BANK_6P) begin
			port_name = "cp_data";
		end else begin
			port_name = "mp_data";
		end
	endfunction

	// One strobe then one idle cycle
	task automatic send_byte(input logic [7:0] idx, input logic [LOAD_ADDR_W-1:0] addr,
			input logic [7:0] data, input logic dl);
		@(posedge clk_sys);
		ioctl_download <= dl;
		ioctl_index    <= idx;
		ioctl_addr     <= addr;
		ioctl_dout     <= data;
		ioctl_wr       <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	// Address on one edge and data valid after the next
	task automatic read_back(input logic [3:0] bank, input logic [18:0] addr,
			output logic [15:0] data);
		@(posedge clk_sys);
		if (int'(bank) == BANK_16S || int'(bank) == BANK_16R) ap_addr <= addr[15:0];
		else if (int'(bank) == BANK_6P) cp_addr <= addr[13:0];
		else mp_addr <= addr;
		@(posedge clk_sys);
		// Address moves on while its data is on the way out
		if (int'(bank) == BANK_16S || int'(bank) == BANK_16R) ap_addr <= ~addr[15:0];
		else if (int'(bank) == BANK_6P) cp_addr <= ~addr[13:0];
		else mp_addr <= ~addr;
		@(negedge clk_sys);
		if (int'(bank) == BANK_16S || int'(bank) == BANK_16R) data = {8'h00, ap_data};
		else if (int'(bank) == BANK_6P) data = {8'h00, cp_data};
		else data = mp_data;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "Value mismatch");
		end
	endtask

	// ####################
	initial begin : stimulus
		entry_t      e;
		logic [15:0] got;
		logic [63:0] exp_dip;
		logic [7:0]  rnd;
		rst <= 1'b1;
		ioctl_download <= 1'b0;
		ioctl_wr <= 1'b0;
		ioctl_index <= 8'h00;
		ioctl_addr <= '0;
		ioctl_dout <= 8'h00;
		mp_addr <= '0;
		ap_addr <= '0;
		cp_addr <= '0;
		repeat (10) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		check_value("dip_sw", dip_sw, 64'h0);
		check_value("game_type", game_type, 64'h68);   // Default 104
		// Pair of strobes per table entry then read-back
		for (int i = 0; i < N_ENTRIES; i++) begin
			e = TABLE[i];
			if (e.bank != NO_LOAD) begin
				send_byte(ROM_IDX, load_addr(e.bank, e.offset, 1'b0), e.b0, 1'b1);
				send_byte(ROM_IDX, load_addr(e.bank, e.offset, 1'b1), e.b1, 1'b1);
			end
			@(posedge clk_sys);
			read_back(e.bank, e.rd_addr, got);
			check_value(port_name(e.bank), 64'(got), 64'(e.exp_val));
		end
		// Download low then a foreign index over the first word
		e = TABLE[0];
		for (int i = 0; i < 4; i++) begin
			rnd = 8'($random(seed));
			send_byte((i < 2) ? ROM_IDX : 8'h03, load_addr(e.bank, e.offset, 1'(i)),
				rnd, (i >= 2));
		end
		repeat (2) @(posedge clk_sys);
		read_back(e.bank, e.rd_addr, got);
		check_value("mp_data", 64'(got), 64'(e.exp_val));
		// DIP bytes 0..7 and a dropped byte 8
		exp_dip = '0;
		for (int i = 0; i < 8; i++) begin
			rnd = 8'($random(seed));
			exp_dip[i*8 +: 8] = rnd;
			send_byte(DIP_IDX, LOAD_ADDR_W'(i), rnd, 1'b1);
		end
		send_byte(DIP_IDX, LOAD_ADDR_W'(8), ~exp_dip[7:0], 1'b1);
		@(negedge clk_sys);
		check_value("dip_sw", dip_sw, exp_dip);
		send_byte(GAME_IDX, '0, 8'h2A, 1'b1);
		@(negedge clk_sys);
		check_value("game_type", game_type, 64'h2A);
		// Second reset brings the default back
		@(posedge clk_sys);
		rst <= 1'b1;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		check_value("game_type", game_type, 64'h68);
		check_value("dip_sw", dip_sw, 64'h0);
		repeat (2) @(posedge clk_sys);
		if (dut0.u_decoder.chk0.err_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Concurrent assertions on the ROM write bus failed %0d times",
				dut0.u_decoder.chk0.err_count);
			$display("Simulation finished: FAIL");
			$fatal(1, "Assertion failures");
		end
	end

	// Bound checker on the decoder
	initial begin : assertion_monitor
		wait (dut0.u_decoder.chk0.err_count != 0);
		$display("A concurrent assertion on the ROM write bus failed");
		$display("Simulation finished: FAIL");
		$fatal(1, "Assertion failure");
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire

// File: all.f
design/rom_pkg.sv
design/rom_wr_if.sv
design/rom_bank.sv
design/load_decoder.sv
design/program_rom.sv
design/sound_char_rom.sv
design/config_regs.sv
design/rom_loader_top.sv
tests/rom_loader_checker.sv
tests/rom_loader_tb.sv
